// File: verilog/boot_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot package
// widths, region sizes and phase codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package boot_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int CTRL_W      = 4;   // byte enables
    localparam int ADDR_MASK_W = 26;  // low user address bits kept

    localparam int WORD_BYTES  = 4;
    localparam int ZERO_BYTES  = 64;  // cleared from address 0
    localparam int IMAGE_BYTES = 32;  // loaded and verified from address 0

    localparam logic [ADDR_W-1:0] ADDR_MASK =
        {{(ADDR_W-ADDR_MASK_W){1'b0}}, {ADDR_MASK_W{1'b1}}};

    // boot phases in the order they run
    localparam int PHASE_W = 3;
    localparam logic [PHASE_W-1:0] PH_CALIB  = PHASE_W'(0);
    localparam logic [PHASE_W-1:0] PH_ZERO   = PHASE_W'(1);
    localparam logic [PHASE_W-1:0] PH_LOAD   = PHASE_W'(2);
    localparam logic [PHASE_W-1:0] PH_VERIFY = PHASE_W'(3);
    localparam logic [PHASE_W-1:0] PH_READY  = PHASE_W'(4);

    // image copier states
    localparam int CP_STATE_W = 2;
    localparam logic [CP_STATE_W-1:0] CP_IDLE = CP_STATE_W'(0);
    localparam logic [CP_STATE_W-1:0] CP_REQ  = CP_STATE_W'(1);
    localparam logic [CP_STATE_W-1:0] CP_WAIT = CP_STATE_W'(2);

endpackage

`default_nettype wire

// File: verilog/boot_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot sequencer
// steps calib, zero, load, verify, ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module boot_sequencer import boot_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_calib_done,
    input  wire                i_zero_done,
    input  wire                i_load_done,
    input  wire                i_verify_done,
    output logic [PHASE_W-1:0] o_phase,
    output logic               o_boot_done
);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_phase <= PH_CALIB;
        end else begin
            case (o_phase)
                PH_CALIB: begin
                    if (i_calib_done) o_phase <= PH_ZERO;
                end
                PH_ZERO: begin
                    if (i_zero_done) o_phase <= PH_LOAD;
                end
                PH_LOAD: begin
                    if (i_load_done) o_phase <= PH_VERIFY;
                end
                PH_VERIFY: begin
                    if (i_verify_done) o_phase <= PH_READY;
                end
                PH_READY: begin
                    o_phase <= PH_READY;  // held until reset
                end
                default: begin
                    o_phase <= PH_CALIB;  // unused codes restart
                end
            endcase
        end
    end

    assign o_boot_done = (o_phase == PH_READY);

endmodule

`default_nettype wire

// File: verilog/zero_filler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zero filler
// clears the low region one word at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module zero_filler import boot_pkg::*; (
    input  wire               clk,
    input  wire               i_rst,
    input  wire               i_start,
    input  wire               i_mem_busy,
    output logic              o_wr_en,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_done
);

    logic              waiting;    // write accepted by the controller
    logic [ADDR_W-1:0] next_addr;

    assign next_addr = o_addr + ADDR_W'(WORD_BYTES);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
            waiting <= 1'b0;
            o_addr  <= '0;
            o_done  <= 1'b0;
        end else if (i_start && !o_done) begin
            if (o_wr_en) begin
                if (i_mem_busy) begin      // controller took it
                    o_wr_en <= 1'b0;
                    waiting <= 1'b1;
                end
            end else if (waiting) begin
                if (!i_mem_busy) begin
                    waiting <= 1'b0;
                    o_addr  <= next_addr;
                    o_done  <= (next_addr >= ADDR_W'(ZERO_BYTES));
                end
            end else if (!i_mem_busy) begin
                o_wr_en <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/image_copier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// image copier
// writes loader words to memory and
// keeps a running checksum of them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module image_copier import boot_pkg::*; (
    input  wire               clk,
    input  wire               i_rst,
    input  wire               i_start,
    input  wire               i_ld_valid,
    input  wire  [DATA_W-1:0] i_ld_data,
    input  wire               i_mem_busy,
    output logic              o_ld_ready,
    output logic              o_wr_en,
    output logic [ADDR_W-1:0] o_addr,
    output logic [DATA_W-1:0] o_wdata,
    output logic [DATA_W-1:0] o_checksum,
    output logic              o_done
);

    logic [CP_STATE_W-1:0] state;
    logic [ADDR_W-1:0]     next_addr;

    assign next_addr  = o_addr + ADDR_W'(WORD_BYTES);
    assign o_ld_ready = i_start && (state == CP_IDLE) && !o_done;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= CP_IDLE;
            o_wr_en    <= 1'b0;
            o_addr     <= '0;
            o_checksum <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                CP_IDLE: begin
                    if (i_ld_valid && o_ld_ready) begin
                        o_checksum <= o_checksum + i_ld_data;  // wraps mod 2^32
                        state      <= CP_REQ;
                    end
                end
                CP_REQ: begin
                    if (o_wr_en && i_mem_busy) begin
                        o_wr_en <= 1'b0;
                        state   <= CP_WAIT;
                    end else if (!o_wr_en && !i_mem_busy) begin
                        o_wr_en <= 1'b1;
                    end
                end
                CP_WAIT: begin
                    if (!i_mem_busy) begin  // write complete
                        o_addr <= next_addr;
                        o_done <= (next_addr >= ADDR_W'(IMAGE_BYTES));
                        state  <= CP_IDLE;
                    end
                end
                default: state <= CP_IDLE;
            endcase
        end
    end

    // loader word held for the write
    always_ff @(posedge clk) begin
        if (i_ld_valid && o_ld_ready) o_wdata <= i_ld_data;
    end

endmodule

`default_nettype wire

// File: verilog/readback_verifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// readback verifier
// reads the image back and compares its
// checksum with the load checksum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module readback_verifier import boot_pkg::*; (
    input  wire               clk,
    input  wire               i_rst,
    input  wire               i_start,
    input  wire               i_mem_busy,
    input  wire  [DATA_W-1:0] i_mem_rdata,
    input  wire  [DATA_W-1:0] i_load_checksum,
    output logic              o_rd_en,
    output logic [ADDR_W-1:0] o_addr,
    output logic [DATA_W-1:0] o_checksum,
    output logic              o_done,
    output logic              o_match
);

    logic              waiting;   // read accepted by the controller
    logic              last_word;
    logic [ADDR_W-1:0] next_addr;
    logic [DATA_W-1:0] sum_next;

    assign next_addr = o_addr + ADDR_W'(WORD_BYTES);
    assign last_word = (next_addr >= ADDR_W'(IMAGE_BYTES));
    assign sum_next  = o_checksum + i_mem_rdata;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rd_en    <= 1'b0;
            waiting    <= 1'b0;
            o_addr     <= '0;
            o_checksum <= '0;
            o_done     <= 1'b0;
            o_match    <= 1'b0;
        end else if (i_start && !o_done) begin
            if (o_rd_en) begin
                if (i_mem_busy) begin
                    o_rd_en <= 1'b0;
                    waiting <= 1'b1;
                end
            end else if (waiting) begin
                if (!i_mem_busy) begin          // rdata valid this cycle
                    waiting    <= 1'b0;
                    o_checksum <= sum_next;
                    o_addr     <= next_addr;
                    if (last_word) begin
                        o_done  <= 1'b1;
                        o_match <= (sum_next == i_load_checksum);
                    end
                end
            end else if (!i_mem_busy) begin
                o_rd_en <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_port_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory port mux
// picks the request source by boot phase
// and opens the user port once ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mem_port_mux import boot_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire  [PHASE_W-1:0] i_phase,
    input  wire                i_zero_wr_en,
    input  wire  [ADDR_W-1:0]  i_zero_addr,
    input  wire                i_copy_wr_en,
    input  wire  [ADDR_W-1:0]  i_copy_addr,
    input  wire  [DATA_W-1:0]  i_copy_wdata,
    input  wire                i_vrfy_rd_en,
    input  wire  [ADDR_W-1:0]  i_vrfy_addr,
    input  wire                i_usr_rd_en,
    input  wire                i_usr_wr_en,
    input  wire  [ADDR_W-1:0]  i_usr_addr,
    input  wire  [DATA_W-1:0]  i_usr_wdata,
    input  wire  [CTRL_W-1:0]  i_usr_ctrl,
    output logic [DATA_W-1:0]  o_usr_rdata,
    output logic               o_usr_busy,
    input  wire                i_mem_busy,
    input  wire  [DATA_W-1:0]  i_mem_rdata,
    output logic               o_mem_rd_en,
    output logic               o_mem_wr_en,
    output logic [ADDR_W-1:0]  o_mem_addr,
    output logic [DATA_W-1:0]  o_mem_wdata,
    output logic [CTRL_W-1:0]  o_mem_ctrl
);

    logic usr_open;
    logic sel_rd;
    logic sel_wr;

    assign usr_open = (i_phase == PH_READY);

    always_comb begin
        sel_rd      = 1'b0;
        sel_wr      = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;   // zero fill data
        case (i_phase)
            PH_ZERO: begin
                sel_wr     = i_zero_wr_en;
                o_mem_addr = i_zero_addr;
            end
            PH_LOAD: begin
                sel_wr      = i_copy_wr_en;
                o_mem_addr  = i_copy_addr;
                o_mem_wdata = i_copy_wdata;
            end
            PH_VERIFY: begin
                sel_rd     = i_vrfy_rd_en;
                o_mem_addr = i_vrfy_addr;
            end
            PH_READY: begin
                sel_rd      = i_usr_rd_en;
                sel_wr      = i_usr_wr_en;
                o_mem_addr  = i_usr_addr & ADDR_MASK;
                o_mem_wdata = i_usr_wdata;
            end
            default: begin
                sel_rd = 1'b0;  // no requests during calibration
            end
        endcase
    end

    // enables leave through flops; dropped as soon as busy shows
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_rd_en <= 1'b0;
            o_mem_wr_en <= 1'b0;
        end else begin
            o_mem_rd_en <= sel_rd && !i_mem_busy;
            o_mem_wr_en <= sel_wr && !i_mem_busy;
        end
    end

    assign o_mem_ctrl  = usr_open ? i_usr_ctrl : '1;  // full words during boot
    assign o_usr_busy  = usr_open ? i_mem_busy : 1'b1;
    assign o_usr_rdata = i_mem_rdata;

endmodule

`default_nettype wire

// File: verilog/boot_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot memory init front end
// sequencer, fill/copy/verify engines and
// the memory port mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module boot_top import boot_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_calib_done,
    // loader stream
    input  wire                i_ld_valid,
    input  wire  [DATA_W-1:0]  i_ld_data,
    output logic               o_ld_ready,
    // user port
    input  wire                i_usr_rd_en,
    input  wire                i_usr_wr_en,
    input  wire  [ADDR_W-1:0]  i_usr_addr,
    input  wire  [DATA_W-1:0]  i_usr_wdata,
    input  wire  [CTRL_W-1:0]  i_usr_ctrl,
    output logic [DATA_W-1:0]  o_usr_rdata,
    output logic               o_usr_busy,
    // memory controller
    output logic               o_mem_rd_en,
    output logic               o_mem_wr_en,
    output logic [ADDR_W-1:0]  o_mem_addr,
    output logic [DATA_W-1:0]  o_mem_wdata,
    output logic [CTRL_W-1:0]  o_mem_ctrl,
    input  wire  [DATA_W-1:0]  i_mem_rdata,
    input  wire                i_mem_busy,
    // status
    output logic [PHASE_W-1:0] o_phase,
    output logic               o_boot_done,
    output logic               o_verify_ok,
    output logic [DATA_W-1:0]  o_load_checksum
);

    logic              zero_done, load_done, verify_done;
    logic              zero_wr_en, copy_wr_en, vrfy_rd_en;
    logic [ADDR_W-1:0] zero_addr, copy_addr, vrfy_addr;
    logic [DATA_W-1:0] copy_wdata;

    boot_sequencer u_seq (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_calib_done  (i_calib_done),
        .i_zero_done   (zero_done),
        .i_load_done   (load_done),
        .i_verify_done (verify_done),
        .o_phase       (o_phase),
        .o_boot_done   (o_boot_done)
    );

    zero_filler u_zero (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (o_phase == PH_ZERO),
        .i_mem_busy (i_mem_busy),
        .o_wr_en    (zero_wr_en),
        .o_addr     (zero_addr),
        .o_done     (zero_done)
    );

    image_copier u_copy (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (o_phase == PH_LOAD),
        .i_ld_valid (i_ld_valid),
        .i_ld_data  (i_ld_data),
        .i_mem_busy (i_mem_busy),
        .o_ld_ready (o_ld_ready),
        .o_wr_en    (copy_wr_en),
        .o_addr     (copy_addr),
        .o_wdata    (copy_wdata),
        .o_checksum (o_load_checksum),
        .o_done     (load_done)
    );

    readback_verifier u_vrfy (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_start         (o_phase == PH_VERIFY),
        .i_mem_busy      (i_mem_busy),
        .i_mem_rdata     (i_mem_rdata),
        .i_load_checksum (o_load_checksum),
        .o_rd_en         (vrfy_rd_en),
        .o_addr          (vrfy_addr),
        .o_checksum      (),   // only compared inside
        .o_done          (verify_done),
        .o_match         (o_verify_ok)
    );

    mem_port_mux u_mux (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_phase      (o_phase),
        .i_zero_wr_en (zero_wr_en),
        .i_zero_addr  (zero_addr),
        .i_copy_wr_en (copy_wr_en),
        .i_copy_addr  (copy_addr),
        .i_copy_wdata (copy_wdata),
        .i_vrfy_rd_en (vrfy_rd_en),
        .i_vrfy_addr  (vrfy_addr),
        .i_usr_rd_en  (i_usr_rd_en),
        .i_usr_wr_en  (i_usr_wr_en),
        .i_usr_addr   (i_usr_addr),
        .i_usr_wdata  (i_usr_wdata),
        .i_usr_ctrl   (i_usr_ctrl),
        .o_usr_rdata  (o_usr_rdata),
        .o_usr_busy   (o_usr_busy),
        .i_mem_busy   (i_mem_busy),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_rd_en  (o_mem_rd_en),
        .o_mem_wr_en  (o_mem_wr_en),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .o_mem_ctrl   (o_mem_ctrl)
    );

endmodule

`default_nettype wire

// File: verification/mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral memory controller
// random busy time of 1 to 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mem_model import boot_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_rd_en,
    input  wire                i_wr_en,
    input  wire  [ADDR_W-1:0]  i_addr,
    input  wire  [DATA_W-1:0]  i_wdata,
    input  wire  [CTRL_W-1:0]  i_ctrl,
    output logic [DATA_W-1:0]  o_rdata,
    output logic               o_busy
);

    logic [DATA_W-1:0] mem [64];
    logic [31:0]       lcg_state;
    int                busy_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h5A5A_0000 ^ (32'(i) * 32'h0001_0101);  // per-word pattern
        end
        lcg_state = 32'd45;
    end

    always @(posedge clk) begin
        if (i_rst) begin
            o_busy    <= 1'b0;
            o_rdata   <= '0;
            busy_left <= 0;
        end else if (o_busy) begin
            if (busy_left <= 1) o_busy <= 1'b0;
            busy_left <= busy_left - 1;
        end else if (i_rd_en || i_wr_en) begin
            lcg_state <= lcg_next(lcg_state);
            busy_left <= int'((lcg_next(lcg_state) >> 16) % 4) + 1;
            o_busy    <= 1'b1;
            if (i_rd_en) o_rdata <= mem[i_addr[7:2]];
            if (i_wr_en) begin
                for (int b = 0; b < CTRL_W; b++) begin
                    if (i_ctrl[b]) mem[i_addr[7:2]][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/boot_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot checker
// watches the DUT ports and counts errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module boot_checker import boot_pkg::*; (
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_calib_done,
    input  wire  [PHASE_W-1:0] i_phase,
    input  wire                i_ld_ready,
    input  wire                i_mem_rd_en,
    input  wire                i_mem_wr_en,
    input  wire  [ADDR_W-1:0]  i_mem_addr,
    input  wire                i_usr_busy,
    input  wire  [DATA_W-1:0]  i_usr_rdata,
    input  wire                i_boot_done,
    input  wire                i_verify_ok,
    input  wire  [DATA_W-1:0]  i_load_checksum,
    input  wire  [DATA_W-1:0]  i_exp_checksum,
    input  wire                i_exp_strobe,
    input  wire  [DATA_W-1:0]  i_exp_rdata,
    output int                 o_errors,
    output int                 o_checks
);

    logic calib_seen;
    logic boot_done_q;

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    task automatic compare(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
        o_checks = o_checks + 1;
        if (got !== exp) begin
            o_errors = o_errors + 1;
            $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string what);
        o_errors = o_errors + 1;
        $display("error @%0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (i_rst) begin
            calib_seen  <= 1'b0;
            boot_done_q <= 1'b0;
        end else begin
            if (i_calib_done) calib_seen <= 1'b1;
            boot_done_q <= i_boot_done;

            if (!calib_seen) begin  // still waiting on the controller
                compare("o_phase", 32'(i_phase), 32'(PH_CALIB));
                compare("o_ld_ready", 32'(i_ld_ready), 32'd0);
                compare("o_mem_rd_en", 32'(i_mem_rd_en), 32'd0);
                compare("o_mem_wr_en", 32'(i_mem_wr_en), 32'd0);
            end

            if (i_phase != PH_READY) begin
                compare("o_usr_busy", 32'(i_usr_busy), 32'd1);
                if ((i_mem_rd_en || i_mem_wr_en) && i_mem_addr >= ADDR_W'(ZERO_BYTES))
                    report("memory access outside the boot region during boot");
            end else if ((i_mem_rd_en || i_mem_wr_en)
                         && i_mem_addr[ADDR_W-1:ADDR_MASK_W] != 0) begin
                report("user address reached memory without its high bits cleared");
            end

            if (i_boot_done && !boot_done_q) begin
                compare("o_load_checksum", i_load_checksum, i_exp_checksum);
                compare("o_verify_ok", 32'(i_verify_ok), 32'd1);
            end

            if (i_exp_strobe) compare("o_usr_rdata", i_usr_rdata, i_exp_rdata);
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_boot_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the boot memory front end
// loader words, boot wait, then user ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_boot_top import boot_pkg::*; ();

    localparam int OP_LD = 0;
    localparam int OP_WR = 1;
    localparam int OP_RD = 2;
    localparam int N_LD  = IMAGE_BYTES / WORD_BYTES;
    localparam int N_OPS = 11;
    localparam int N_ENT = N_LD + N_OPS;
    localparam int LIMIT = (ZERO_BYTES / WORD_BYTES + 2 * N_LD + N_OPS) * 8 + 200;

    logic               clk;
    logic               i_rst;
    logic               calib_done;
    logic               ld_valid;
    logic [DATA_W-1:0]  ld_data;
    logic               ld_ready;
    logic               usr_rd_en;
    logic               usr_wr_en;
    logic [ADDR_W-1:0]  usr_addr;
    logic [DATA_W-1:0]  usr_wdata;
    logic [CTRL_W-1:0]  usr_ctrl;
    logic [DATA_W-1:0]  usr_rdata;
    logic               usr_busy;
    logic               mem_rd_en;
    logic               mem_wr_en;
    logic [ADDR_W-1:0]  mem_addr;
    logic [DATA_W-1:0]  mem_wdata;
    logic [CTRL_W-1:0]  mem_ctrl;
    logic [DATA_W-1:0]  mem_rdata;
    logic               mem_busy;
    logic [PHASE_W-1:0] phase;
    logic               boot_done;
    logic               verify_ok;
    logic [DATA_W-1:0]  load_checksum;

    logic [DATA_W-1:0]  exp_checksum;
    logic               exp_strobe;
    logic [DATA_W-1:0]  exp_rdata;
    int                 errors;
    int                 checks;
    int                 cycles;

    // stimulus table: kind, address, data, expected read data
    int                 op_kind [N_ENT];
    logic [ADDR_W-1:0]  op_addr [N_ENT];
    logic [DATA_W-1:0]  op_data [N_ENT];
    logic [DATA_W-1:0]  op_exp  [N_ENT];

    boot_top dut (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_calib_done    (calib_done),
        .i_ld_valid      (ld_valid),
        .i_ld_data       (ld_data),
        .o_ld_ready      (ld_ready),
        .i_usr_rd_en     (usr_rd_en),
        .i_usr_wr_en     (usr_wr_en),
        .i_usr_addr      (usr_addr),
        .i_usr_wdata     (usr_wdata),
        .i_usr_ctrl      (usr_ctrl),
        .o_usr_rdata     (usr_rdata),
        .o_usr_busy      (usr_busy),
        .o_mem_rd_en     (mem_rd_en),
        .o_mem_wr_en     (mem_wr_en),
        .o_mem_addr      (mem_addr),
        .o_mem_wdata     (mem_wdata),
        .o_mem_ctrl      (mem_ctrl),
        .i_mem_rdata     (mem_rdata),
        .i_mem_busy      (mem_busy),
        .o_phase         (phase),
        .o_boot_done     (boot_done),
        .o_verify_ok     (verify_ok),
        .o_load_checksum (load_checksum)
    );

    mem_model u_mem (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_rd_en (mem_rd_en),
        .i_wr_en (mem_wr_en),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .i_ctrl  (mem_ctrl),
        .o_rdata (mem_rdata),
        .o_busy  (mem_busy)
    );

    boot_checker u_chk (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_calib_done    (calib_done),
        .i_phase         (phase),
        .i_ld_ready      (ld_ready),
        .i_mem_rd_en     (mem_rd_en),
        .i_mem_wr_en     (mem_wr_en),
        .i_mem_addr      (mem_addr),
        .i_usr_busy      (usr_busy),
        .i_usr_rdata     (usr_rdata),
        .i_boot_done     (boot_done),
        .i_verify_ok     (verify_ok),
        .i_load_checksum (load_checksum),
        .i_exp_checksum  (exp_checksum),
        .i_exp_strobe    (exp_strobe),
        .i_exp_rdata     (exp_rdata),
        .o_errors        (errors),
        .o_checks        (checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic set_entry(input int idx, input int kind, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        op_kind[idx] = kind;
        op_addr[idx] = addr;
        op_data[idx] = data;
        op_exp[idx]  = exp;
    endtask

    task automatic fill_table();
        set_entry(0,  OP_LD, '0, 32'h1234_5678, '0);
        set_entry(1,  OP_LD, '0, 32'h9ABC_DEF0, '0);
        set_entry(2,  OP_LD, '0, 32'hFFFF_FFFF, '0);
        set_entry(3,  OP_LD, '0, 32'h0000_0001, '0);
        set_entry(4,  OP_LD, '0, 32'h8000_0000, '0);
        set_entry(5,  OP_LD, '0, 32'hCAFE_F00D, '0);
        set_entry(6,  OP_LD, '0, 32'h0BAD_C0DE, '0);
        set_entry(7,  OP_LD, '0, 32'h7654_3210, '0);
        set_entry(8,  OP_RD, 32'h0000_0000, '0, 32'h1234_5678);
        set_entry(9,  OP_RD, 32'h0000_0004, '0, 32'h9ABC_DEF0);
        set_entry(10, OP_RD, 32'h0000_0010, '0, 32'h8000_0000);
        set_entry(11, OP_RD, 32'h0000_001C, '0, 32'h7654_3210);
        set_entry(12, OP_RD, 32'h0000_0020, '0, 32'h0000_0000);
        set_entry(13, OP_RD, 32'h0000_0030, '0, 32'h0000_0000);
        set_entry(14, OP_RD, 32'h0000_003C, '0, 32'h0000_0000);
        set_entry(15, OP_RD, 32'h0000_0070, '0, 32'h5A46_1C1C);  // untouched fill
        set_entry(16, OP_WR, 32'hFC00_0088, 32'h1357_9BDF, '0);
        set_entry(17, OP_RD, 32'hFC00_0088, '0, 32'h1357_9BDF);
        set_entry(18, OP_RD, 32'h0000_0088, '0, 32'h1357_9BDF);  // masked alias
    endtask

    task automatic load_word(input logic [DATA_W-1:0] word);
        ld_valid = 1'b1;
        ld_data  = word;
        while (!ld_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);  // taken on this edge
        #1;
        ld_valid = 1'b0;
    endtask

    task automatic user_access(input int kind, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        usr_rd_en = (kind == OP_RD);
        usr_wr_en = (kind == OP_WR);
        usr_addr  = addr;
        usr_wdata = data;
        while (!usr_busy) begin
            @(posedge clk);
            #1;
        end
        usr_rd_en = 1'b0;
        usr_wr_en = 1'b0;
        while (usr_busy) begin
            @(posedge clk);
            #1;
        end
        if (kind == OP_RD) begin  // rdata held until the next access
            exp_strobe = 1'b1;
            exp_rdata  = exp;
            @(posedge clk);
            #1;
            exp_strobe = 1'b0;
        end
    endtask

    initial begin
        i_rst        = 1'b1;
        calib_done   = 1'b0;
        ld_valid     = 1'b0;
        ld_data      = '0;
        usr_rd_en    = 1'b0;
        usr_wr_en    = 1'b0;
        usr_addr     = '0;
        usr_wdata    = '0;
        usr_ctrl     = '1;
        exp_strobe   = 1'b0;
        exp_rdata    = '0;
        exp_checksum = '0;
        fill_table();
        for (int i = 0; i < N_ENT; i++) begin
            if (op_kind[i] == OP_LD) exp_checksum = exp_checksum + op_data[i];
        end
        repeat (4) @(posedge clk);
        #1;
        i_rst = 1'b0;

        // a user write during boot must never land at 0x70
        usr_wr_en = 1'b1;
        usr_addr  = 32'h0000_0070;
        usr_wdata = 32'hDEAD_BEEF;
        repeat (6) @(posedge clk);
        #1;
        calib_done = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        usr_wr_en = 1'b0;

        for (int i = 0; i < N_ENT; i++) begin
            if (op_kind[i] == OP_LD) begin
                load_word(op_data[i]);
            end else begin
                while (!boot_done) begin
                    @(posedge clk);
                    #1;
                end
                user_access(op_kind[i], op_addr[i], op_data[i], op_exp[i]);
            end
        end
        repeat (2) @(posedge clk);
        #1;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit scaled by the number of memory words
    initial cycles = 0;
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/boot_pkg.sv
verilog/boot_sequencer.sv
verilog/zero_filler.sv
verilog/image_copier.sv
verilog/readback_verifier.sv
verilog/mem_port_mux.sv
verilog/boot_top.sv
verification/mem_model.sv
verification/boot_checker.sv
verification/tb_boot_top.sv

// File: Makefile
TOP := tb_boot_top

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
